// File: run_sim.sh
#!/bin/sh
# build and run the SRT divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module tb_srt_divider \
	-j 0

./obj_dir/Vtb_srt_divider > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0

// File: sources.f
+incdir+.
srt_pkg.sv
srt_qds.sv
srt_remainder.sv
srt_quotient_otf.sv
srt_result_fix.sv
srt_ctrl.sv
srt_divider.sv
tb_srt_divider.sv

// File: srt_ctrl.sv
`timescale 1ns/10ps
`include "srt_defines.svh"

module srt_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic busy,
	output logic load,     // operand capture at the accepting edge
	output logic norm_en,
	output logic iter_en,
	output logic fix_en,
	output logic done
);

	srt_pkg::ctrl_state_t state_q;
	logic [3:0]           cnt_q;   // iteration count
	logic                 done_q;

	assign busy    = (state_q != srt_pkg::st_idle) | done_q; // through the done cycle
	assign load    = start & ~busy;                          // start while busy dropped
	assign norm_en = (state_q == srt_pkg::st_norm);
	assign iter_en = (state_q == srt_pkg::st_iter);
	assign fix_en  = (state_q == srt_pkg::st_fix);
	assign done    = done_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= srt_pkg::st_idle;
			cnt_q   <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= fix_en;  // one cycle after the fix
			case (state_q)
				srt_pkg::st_idle: begin
					if (load)
						state_q <= srt_pkg::st_norm;
				end
				srt_pkg::st_norm: begin
					cnt_q   <= '0;
					state_q <= srt_pkg::st_iter;
				end
				srt_pkg::st_iter: begin
					cnt_q <= cnt_q + 4'd1;
					if (cnt_q == 4'(`SRT_ITERS - 1))
						state_q <= srt_pkg::st_fix;
				end
				srt_pkg::st_fix: begin
					state_q <= srt_pkg::st_idle;
				end
				default: begin
					state_q <= srt_pkg::st_idle;
				end
			endcase
		end
	end

	// idle again right after the pulse
	assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
		else $error("srt_ctrl: busy after done");

	// fixed latency from the accepting edge
	assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(load, `SRT_LATENCY))
		else $error("srt_ctrl: done off the fixed latency");

endmodule

// File: srt_defines.svh
`ifndef SRT_DEFINES_SVH
`define SRT_DEFINES_SVH

// operand width in bits, dividend and divisor both unsigned
`define SRT_WIDTH 32

// radix-4, two quotient bits per iteration
`define SRT_ITERS (`SRT_WIDTH / 2)

// partial remainder, two's complement
// sign plus two integer bits cover 4w up to 8/3 of the divisor
// one more guard bit on top
`define SRT_REM_WIDTH (`SRT_WIDTH + 4)

// normalization shift amount, 0..32 (32 only for a zero divisor)
`define SRT_LZ_WIDTH 6

// start edge to done pulse
// one normalize cycle, the iterations, one fix cycle, one done cycle
`define SRT_LATENCY (`SRT_ITERS + 3)

`endif

// File: srt_divider.sv
`timescale 1ns/10ps

module srt_divider (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  srt_pkg::operand_t    dividend,
	input  srt_pkg::operand_t    divisor,
	output logic                 busy,
	output logic                 done,
	output srt_pkg::div_result_t result
);

	logic              load;
	logic              norm_en;
	logic              iter_en;
	logic              fix_en;
	srt_pkg::ridx_t    r_idx;
	srt_pkg::didx_t    d_idx;
	srt_pkg::qdigit_t  digit;     // shared by both datapaths each iteration
	srt_pkg::prem_t    prem;
	srt_pkg::operand_t dnorm;
	srt_pkg::shamt_t   shamt;
	logic              div_by_zero;
	srt_pkg::operand_t dividend_q;
	srt_pkg::operand_t q;
	srt_pkg::operand_t qm;

	srt_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .load(load),
		.norm_en(norm_en), .iter_en(iter_en), .fix_en(fix_en), .done(done)
	);

	srt_qds u_qds (.r_idx(r_idx), .d_idx(d_idx), .digit(digit));

	srt_remainder u_rem (
		.clk(clk), .rst_n(rst_n), .load(load), .norm_en(norm_en), .iter_en(iter_en),
		.dividend(dividend), .divisor(divisor), .digit(digit),
		.r_idx(r_idx), .d_idx(d_idx), .prem(prem), .dnorm(dnorm), .shamt(shamt),
		.div_by_zero(div_by_zero), .dividend_q(dividend_q)
	);

	srt_quotient_otf u_otf (
		.clk(clk), .rst_n(rst_n), .load(load), .iter_en(iter_en),
		.digit(digit), .q(q), .qm(qm)
	);

	srt_result_fix u_fix (
		.clk(clk), .rst_n(rst_n), .fix_en(fix_en), .prem(prem), .dnorm(dnorm),
		.shamt(shamt), .div_by_zero(div_by_zero), .dividend_hold(dividend_q),
		.q(q), .qm(qm), .result(result)
	);

endmodule

// File: srt_pkg.sv
`include "srt_defines.svh"

package srt_pkg;

	typedef logic [`SRT_WIDTH-1:0]     operand_t; // dividend, divisor, quotient, remainder
	typedef logic [`SRT_REM_WIDTH-1:0] prem_t;    // partial remainder, signed
	typedef logic [`SRT_LZ_WIDTH-1:0]  shamt_t;   // leading-zero shift

	// sign plus four bits, units of 1/8 of the normalized divisor scale
	typedef logic [4:0] ridx_t;
	// 0.1xxx after normalization, top bit always zero
	typedef logic [4:0] didx_t;

	// signed quotient digit, negative one folded to 111
	typedef enum logic [2:0] {
		q_zero = 3'b000,
		q_pos1 = 3'b001,
		q_pos2 = 3'b010,
		q_neg2 = 3'b110,
		q_neg1 = 3'b111
	} qdigit_t;

	typedef enum logic [1:0] {
		st_idle,
		st_norm,
		st_iter,
		st_fix
	} ctrl_state_t;

	typedef struct packed {
		operand_t quotient;
		operand_t remainder;
		logic     div_by_zero;
	} div_result_t;

endpackage

// File: srt_qds.sv
`timescale 1ns/10ps

module srt_qds (
	input  srt_pkg::ridx_t   r_idx, // truncated estimate of 4w
	input  srt_pkg::didx_t   d_idx, // truncated normalized divisor
	output srt_pkg::qdigit_t digit
);

	logic       r_neg;   // estimate sign
	logic [4:0] r_mag;   // estimate magnitude
	logic [3:0] zero_lim; // digit is zero below this
	logic [3:0] two_lim;  // magnitude two at or above this
	logic       no_sel;  // divisor not normalized
	logic       sel_zero;
	logic       sel_two;
	logic [2:0] raw;     // {sign, magnitude} before the fold

	assign r_neg = r_idx[4];
	assign r_mag = r_neg ? (~r_idx + 5'd1) : r_idx; // 10000 is saturated away upstream

	// thresholds per divisor interval
	// negative side sits one step higher since truncation rounds toward -inf
	always_comb begin
		zero_lim = 4'd0;
		two_lim  = 4'd0;
		no_sel   = 1'b0;
		case (d_idx)
			5'b01000: begin
				zero_lim = r_neg ? 4'd3 : 4'd2;
				two_lim  = r_neg ? 4'd7 : 4'd6;
			end
			5'b01001: begin
				zero_lim = r_neg ? 4'd4 : 4'd2;
				two_lim  = r_neg ? 4'd8 : 4'd7;
			end
			5'b01010: begin
				zero_lim = r_neg ? 4'd4 : 4'd3;
				two_lim  = r_neg ? 4'd9 : 4'd8;
			end
			5'b01011: begin
				zero_lim = r_neg ? 4'd4 : 4'd3;
				two_lim  = r_neg ? 4'd10 : 4'd9;
			end
			5'b01100: begin
				zero_lim = r_neg ? 4'd5 : 4'd4;
				two_lim  = r_neg ? 4'd11 : 4'd9;
			end
			5'b01101: begin
				zero_lim = r_neg ? 4'd5 : 4'd4;
				two_lim  = r_neg ? 4'd11 : 4'd10;
			end
			5'b01110: begin
				zero_lim = r_neg ? 4'd5 : 4'd4;
				two_lim  = r_neg ? 4'd12 : 4'd11;
			end
			5'b01111: begin
				zero_lim = 4'd5; // same on both sides here
				two_lim  = r_neg ? 4'd13 : 4'd12;
			end
			default: begin
				no_sel = 1'b1; // zero divisor leaves the remainder untouched
			end
		endcase
	end

	assign sel_zero = no_sel | (r_mag[3:0] < zero_lim);
	assign sel_two  = ~sel_zero & (r_mag[3:0] >= two_lim);

	always_comb begin
		raw[2]   = r_neg & ~sel_zero;           // no negative zero
		raw[1:0] = sel_zero ? 2'b00 : (sel_two ? 2'b10 : 2'b01);
	end

	// 101 folds to 111 and the rest map straight onto the enum
	assign digit = (raw == 3'b101) ? srt_pkg::q_neg1 : srt_pkg::qdigit_t'(raw);

	// -16 has no 4-bit magnitude and would select a zero digit
	always_comb begin
		assert (r_idx != 5'b10000)
			else $error("srt_qds: remainder estimate not saturated %b", r_idx);
	end

endmodule

// File: srt_quotient_otf.sv
`timescale 1ns/10ps
`include "srt_defines.svh"

module srt_quotient_otf (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load,
	input  logic              iter_en,
	input  srt_pkg::qdigit_t  digit,
	output srt_pkg::operand_t q,  // digits so far
	output srt_pkg::operand_t qm  // same minus one
);

	srt_pkg::operand_t q_nxt;
	srt_pkg::operand_t qm_nxt;

	// append two bits per digit, never a carry
	// a negative digit borrows from qm
	always_comb begin
		case (digit)
			srt_pkg::q_pos1: begin
				q_nxt  = {q[`SRT_WIDTH-3:0], 2'b01};
				qm_nxt = {q[`SRT_WIDTH-3:0], 2'b00};
			end
			srt_pkg::q_pos2: begin
				q_nxt  = {q[`SRT_WIDTH-3:0], 2'b10};
				qm_nxt = {q[`SRT_WIDTH-3:0], 2'b01};
			end
			srt_pkg::q_neg1: begin
				q_nxt  = {qm[`SRT_WIDTH-3:0], 2'b11}; // 4*qm + 3
				qm_nxt = {qm[`SRT_WIDTH-3:0], 2'b10};
			end
			srt_pkg::q_neg2: begin
				q_nxt  = {qm[`SRT_WIDTH-3:0], 2'b10}; // 4*qm + 2
				qm_nxt = {qm[`SRT_WIDTH-3:0], 2'b01};
			end
			default: begin
				q_nxt  = {q[`SRT_WIDTH-3:0], 2'b00};
				qm_nxt = {qm[`SRT_WIDTH-3:0], 2'b11};
			end
		endcase
	end

	// qm only feeds q once q is nonzero
	// a leading negative digit cannot occur, the first remainder is positive
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q  <= '0;
			qm <= '0;
		end else if (load) begin
			q  <= '0;
			qm <= '0;
		end else if (iter_en) begin
			q  <= q_nxt;
			qm <= qm_nxt;
		end
	end

endmodule

// File: srt_remainder.sv
`timescale 1ns/10ps
`include "srt_defines.svh"

module srt_remainder (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load,
	input  logic              norm_en,
	input  logic              iter_en,
	input  srt_pkg::operand_t dividend,
	input  srt_pkg::operand_t divisor,
	input  srt_pkg::qdigit_t  digit,
	output srt_pkg::ridx_t    r_idx,
	output srt_pkg::didx_t    d_idx,
	output srt_pkg::prem_t    prem,
	output srt_pkg::operand_t dnorm,
	output srt_pkg::shamt_t   shamt,
	output logic              div_by_zero,
	output srt_pkg::operand_t dividend_q
);

	srt_pkg::operand_t        divisor_q;
	srt_pkg::operand_t        lo;        // dividend bits still to shift in, msb first
	srt_pkg::shamt_t          lz;
	logic [2*`SRT_WIDTH-1:0]  xs;        // dividend shifted like the divisor
	srt_pkg::prem_t           shifted;   // 4w plus two incoming bits
	srt_pkg::prem_t           dn1;
	srt_pkg::prem_t           dn2;
	srt_pkg::prem_t           mag;
	srt_pkg::prem_t           prem_nxt;
	logic [2:0]               hi;        // bits above the index window

	always_ff @(posedge clk) begin
		if (load) begin
			dividend_q <= dividend;
			divisor_q  <= divisor;
		end
	end

	// leading zeros, highest set bit wins
	always_comb begin
		lz = srt_pkg::shamt_t'(`SRT_WIDTH); // zero divisor
		for (int i = 0; i < `SRT_WIDTH; i++) begin
			if (divisor_q[i])
				lz = srt_pkg::shamt_t'(`SRT_WIDTH - 1 - i);
		end
	end

	assign xs = {{`SRT_WIDTH{1'b0}}, dividend_q} << lz;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shamt       <= '0;
			div_by_zero <= 1'b0;
		end else if (norm_en) begin
			shamt       <= lz;
			div_by_zero <= (divisor_q == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (norm_en) begin
			dnorm <= divisor_q << lz;                                 // msb set now
			prem  <= {{(`SRT_REM_WIDTH-`SRT_WIDTH+1){1'b0}}, xs[2*`SRT_WIDTH-1:`SRT_WIDTH+1]};
			lo    <= xs[`SRT_WIDTH:1];                                // lsb kept for the fixer
		end else if (iter_en) begin
			prem  <= prem_nxt;
			lo    <= {lo[`SRT_WIDTH-3:0], 2'b00};
		end
	end

	assign shifted = {prem[`SRT_REM_WIDTH-3:0], lo[`SRT_WIDTH-1:`SRT_WIDTH-2]};

	assign dn1 = {{(`SRT_REM_WIDTH-`SRT_WIDTH){1'b0}}, dnorm};
	assign dn2 = {dn1[`SRT_REM_WIDTH-2:0], 1'b0};

	// digit bits: [2] sign, 10 means two, x1 means one
	always_comb begin
		if (digit[1] && !digit[0])
			mag = dn2;
		else if (digit[0])
			mag = dn1;
		else
			mag = '0;
		prem_nxt = digit[2] ? (shifted + mag) : (shifted + (~mag + 1'b1)); // w' = 4w - q*d
	end

	// 1/8 units of the divisor scale, saturated to +-15
	// -16 would read as magnitude zero in the table
	assign hi = shifted[`SRT_REM_WIDTH-1:`SRT_REM_WIDTH-3];
	always_comb begin
		if (hi == 3'b000)
			r_idx = shifted[`SRT_REM_WIDTH-3:`SRT_REM_WIDTH-7];
		else if (hi == 3'b111)
			r_idx = (shifted[`SRT_REM_WIDTH-4:`SRT_REM_WIDTH-7] == 4'b0000) ?
				5'b10001 : shifted[`SRT_REM_WIDTH-3:`SRT_REM_WIDTH-7];
		else
			r_idx = hi[2] ? 5'b10001 : 5'b01111;
	end

	assign d_idx = {1'b0, dnorm[`SRT_WIDTH-1:`SRT_WIDTH-4]};

	// the table assumes 0.1xxx, so the shift must land the msb
	assert property (@(posedge clk) disable iff (!rst_n)
		norm_en |=> (dnorm[`SRT_WIDTH-1] || div_by_zero))
		else $error("srt_remainder: divisor not normalized");

endmodule

// File: srt_result_fix.sv
`timescale 1ns/10ps
`include "srt_defines.svh"

module srt_result_fix (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fix_en,
	input  srt_pkg::prem_t       prem,          // final partial remainder
	input  srt_pkg::operand_t    dnorm,
	input  srt_pkg::shamt_t      shamt,
	input  logic                 div_by_zero,
	input  srt_pkg::operand_t    dividend_hold,
	input  srt_pkg::operand_t    q,
	input  srt_pkg::operand_t    qm,
	output srt_pkg::div_result_t result
);

	logic                 rem_neg;
	srt_pkg::prem_t       dn_ext;
	srt_pkg::prem_t       r_pos;      // remainder after add-back
	srt_pkg::operand_t    q_sel;
	logic                 x0;         // dividend lsb held back from the recurrence
	logic [`SRT_WIDTH+1:0] t;
	logic [`SRT_WIDTH+1:0] dn_t;
	logic                 last_bit;   // quotient lsb
	logic [`SRT_WIDTH+1:0] t_sub;
	srt_pkg::operand_t    rem_norm;   // still scaled by 2^shamt
	srt_pkg::div_result_t res_nxt;

	assign rem_neg = prem[`SRT_REM_WIDTH-1];
	assign dn_ext  = {{(`SRT_REM_WIDTH-`SRT_WIDTH){1'b0}}, dnorm};
	assign r_pos   = rem_neg ? (prem + dn_ext) : prem;
	assign q_sel   = rem_neg ? qm : q;

	// iterations ran on the shifted dividend over two, one restoring step left
	assign x0    = (shamt == '0) ? dividend_hold[0] : 1'b0;
	assign t     = {r_pos[`SRT_WIDTH:0], x0};
	assign dn_t  = {2'b00, dnorm};
	assign last_bit = (t >= dn_t);
	assign t_sub = last_bit ? (t - dn_t) : t;
	assign rem_norm = t_sub[`SRT_WIDTH-1:0];

	always_comb begin
		if (div_by_zero) begin
			res_nxt.quotient  = '1;
			res_nxt.remainder = dividend_hold;
		end else begin
			res_nxt.quotient  = {q_sel[`SRT_WIDTH-2:0], last_bit};
			res_nxt.remainder = rem_norm >> shamt; // undo the pre-shift
		end
		res_nxt.div_by_zero = div_by_zero;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			result <= '0;
		else if (fix_en)
			result <= res_nxt;   // held until the next fix
	end

	// depends on the digit table keeping the remainder bounded
	assert property (@(posedge clk) disable iff (!rst_n)
		(fix_en && !div_by_zero) |-> (rem_norm < dnorm))
		else $error("srt_result_fix: remainder not below divisor");

endmodule

// File: tb_srt_divider.sv
`timescale 1ns/10ps
`include "srt_defines.svh"

module tb_srt_divider;

	logic                 clk;
	logic                 rst_n;
	logic                 start;
	srt_pkg::operand_t    dividend;
	srt_pkg::operand_t    divisor;
	logic                 busy;
	logic                 done;
	srt_pkg::div_result_t result;

	srt_pkg::div_result_t exp_q[$]; // expected results in issue order
	int                   errors;
	int                   checks;
	bit                   timed_out;   // skip the rest after a hang

	srt_divider i_dut (
		.clk(clk), .rst_n(rst_n), .start(start), .dividend(dividend), .divisor(divisor),
		.busy(busy), .done(done), .result(result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// plain integer division with all ones and the dividend back for a zero divisor
	function automatic srt_pkg::div_result_t ref_divide(input srt_pkg::operand_t a,
			input srt_pkg::operand_t b);
		srt_pkg::div_result_t r;
		if (b == '0) begin
			r.quotient    = '1;
			r.remainder   = a;
			r.div_by_zero = 1'b1;
		end else begin
			r.quotient    = a / b;
			r.remainder   = a % b;
			r.div_by_zero = 1'b0;
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
		end
	endtask

	// one division from start to done
	// poke raises start again mid-run with other operands that must be dropped
	task automatic run_div(input srt_pkg::operand_t a, input srt_pkg::operand_t b,
			input bit poke);
		int cycles;
		bit seen;
		cycles = 0;
		seen   = 1'b0;
		if (!timed_out) begin
			@(posedge clk);
			#1;
			check_value("busy", 64'd0, {63'd0, busy}); // idle again after the last done
			start    = 1'b1;
			dividend = a;
			divisor  = b;
			exp_q.push_back(ref_divide(a, b));
			while (!seen && cycles < 40) begin
				@(posedge clk);
				cycles++;
				#1;
				start = 1'b0;
				if (poke && cycles == 6) begin
					start    = 1'b1;
					dividend = ~a;
					divisor  = b ^ 32'h5a5a_0001;
				end
				@(negedge clk); // outputs settled
				check_value("busy", 64'd1, {63'd0, busy}); // high through the done cycle
				if (done)
					seen = 1'b1;
			end
			if (!seen) begin
				errors++;
				timed_out = 1'b1;
				$display("ERROR: done never arrived within 40 cycles, dividend %h divisor %h",
					a, b);
			end else begin
				check_value("latency", 64'(`SRT_LATENCY), 64'(cycles));
			end
		end
	endtask

	// compares every done pulse against the oldest expected result
	always @(negedge clk) begin : compare_proc
		srt_pkg::div_result_t exp;
		if (rst_n && done) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR: done pulsed with no division pending");
			end else begin
				exp = exp_q.pop_front();
				check_value("quotient", 64'(exp.quotient), 64'(result.quotient));
				check_value("remainder", 64'(exp.remainder), 64'(result.remainder));
				check_value("div_by_zero", 64'(exp.div_by_zero), 64'(result.div_by_zero));
			end
		end
	end

	initial begin
		srt_pkg::operand_t a;
		srt_pkg::operand_t b;
		srt_pkg::operand_t mask;
		int unsigned       w;
		int                n;
		rst_n     = 1'b0;
		start     = 1'b0;
		dividend  = '0;
		divisor   = '0;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		void'($urandom(32'h6ec45d4c));

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("busy", 64'd0, {63'd0, busy}); // idle out of reset
		check_value("done", 64'd0, {63'd0, done});
		check_value("quotient", 64'd0, 64'(result.quotient));
		check_value("remainder", 64'd0, 64'(result.remainder));
		check_value("div_by_zero", 64'd0, 64'(result.div_by_zero));

		// directed corners
		run_div(32'd1, 32'd1, 1'b0);
		run_div(32'd100, 32'd7, 1'b0);
		run_div(32'hffff_ffff, 32'd1, 1'b0);
		run_div(32'hffff_ffff, 32'hffff_ffff, 1'b0);
		run_div(32'd5, 32'd9, 1'b0);
		run_div(32'h8000_0000, 32'h7fff_ffff, 1'b0);

		// powers of two hit every normalization shift
		for (int i = 0; i < 32; i++) begin
			run_div(32'hdead_beef ^ 32'(i * 32'h0101_0101), 32'h1 << i, 1'b0);
			run_div(32'h1 << i, 32'd3, 1'b0);
			run_div(32'hffff_ffff, (32'h1 << i) | 32'h1, 1'b0);
		end

		// divide by zero keeps the same latency
		run_div(32'd0, 32'd0, 1'b0);
		run_div(32'd12345, 32'd0, 1'b0);
		run_div(32'hffff_ffff, 32'd0, 1'b1);

		// start while busy must not disturb result or timing
		run_div(32'h1234_5678, 32'd99, 1'b1);
		run_div(32'hcafe_f00d, 32'h0001_0003, 1'b1);

		// random pairs with a random divisor width so small divisors show up
		for (int i = 0; i < 2000; i++) begin
			w    = $urandom_range(1, 32);
			mask = (w == 32) ? '1 : ((32'h1 << w) - 32'h1);
			b    = $urandom & mask;
			a    = $urandom;
			if ($urandom_range(0, 3) == 0)
				a = a >> $urandom_range(0, 31); // short dividends now and then
			run_div(a, b, (i % 50) == 7);
		end

		// let the compare process catch up with the last done
		n = 0;
		while (exp_q.size() != 0 && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("ERROR: %0d results never came back", exp_q.size());
		end

		$display("errors: %0d  checks: %0d", errors, checks);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
